// File: cpu_core_testdata.txt
# P addr word = preload memory word at byte address, W addr data = next expected store
# C count = number of expected stores, all values hex except count
P 0000 4E10  # addi r7, r0, 16
P 0002 0FC7  # add r7, r7, r7 -> 32
P 0004 0FC7  # add r7, r7, r7 -> 64
P 0006 0FC7  # add r7, r7, r7 -> 0x80 data base
P 0008 4205  # addi r1, r0, 5
P 000A 440C  # addi r2, r0, 12
P 000C 0642  # add r3, r1, r2 -> 0x0011
P 000E 67C0  # st r3, 0(r7)
P 0010 1842  # sub r4, r1, r2 -> 0xfff9
P 0012 69C1  # st r4, 1(r7)
P 0014 2B02  # and r5, r4, r2 -> 0x0008
P 0016 6BC2  # st r5, 2(r7)
P 0018 3C42  # or r6, r1, r2 -> 0x000d
P 001A 6DC3  # st r6, 3(r7)
P 001C 427D  # addi r1, r1, -3 -> 0x0002
P 001E 63C4  # st r1, 4(r7)
P 0020 55FE  # ld r2, -2(r7) reads 0x7c
P 0022 65C5  # st r2, 5(r7)
P 0024 7241  # beq r1, r1, +1 taken
P 0026 67C6  # st r3, 6(r7) skipped
P 0028 7641  # beq r1, r3, +1 not taken
P 002A 6DC7  # st r6, 7(r7)
P 002C 8000  # halt
P 007C BEEF  # load source
W 0080 0011
W 0082 FFF9
W 0084 0008
W 0086 000D
W 0088 0002
W 008A BEEF
W 008E 000D
C 7

// File: cpu_core.f
cpu_pkg.sv
phase_sequencer.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
axil_master.sv
writeback_stage.sv
cpu_core.sv
tb_cpu_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the cpu_core testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f cpu_core.f --top-module tb_cpu_core -o tb_cpu_core \
    && ./obj_dir/tb_cpu_core | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb_cpu_core.sv
`default_nettype none

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int clk_half    = 20;   // 40 unit period
    localparam int drive_delay = 2;    // inputs move just after the edge
    localparam int rst_cycles  = 2;
    localparam int mem_words   = 256;

    logic      clk;
    logic      rst_n;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    logic      halted;

    logic [data_w-1:0] mem [mem_words];  // slave memory indexed by word
    logic [31:0]       exp_q [$];         // expected stores as {addr, data}
    int                exp_count;
    int                store_count;
    int                timeout_cycles;
    logic              first_read;

    cpu_core i_cpu_core (
        .clk, .rst_n, .axil_req, .axil_rsp, .halted
    );

    always #(clk_half) clk = ~clk;

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            fail_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);  // dut outputs settled so inputs may move
    endtask

    function automatic logic [31:0] handshake_bits();
        return 32'({axil_req.awvalid, axil_req.wvalid, axil_req.arvalid,
                    axil_req.rready, axil_req.bready});
    endfunction

    // 0 to 3 idle cycles while open channels hold valid and payload
    task automatic random_wait(input logic hold_ar, input logic hold_aw, input logic hold_w,
                               input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        int n;
        n = $urandom_range(3, 0);
        repeat (n) begin
            next_cycle();
            if (hold_ar) begin
                check_value("arvalid", 32'(axil_req.arvalid), 1);
                check_value("araddr", 32'(axil_req.araddr), 32'(addr));
            end
            if (hold_aw) begin
                check_value("awvalid", 32'(axil_req.awvalid), 1);
                check_value("awaddr", 32'(axil_req.awaddr), 32'(addr));
            end
            if (hold_w) begin
                check_value("wvalid", 32'(axil_req.wvalid), 1);
                check_value("wdata", 32'(axil_req.wdata), 32'(data));
            end
        end
    endtask

    task automatic serve_read();
        logic [addr_w-1:0] addr;
        logic              seen;
        addr = axil_req.araddr;
        check_value("araddr bit 0", 32'(addr[0]), 0);  // word aligned fetch/ld
        if (first_read) begin
            check_value("first araddr", 32'(addr), 0);  // reset pc
            first_read = 1'b0;
        end
        random_wait(1'b1, 1'b0, 1'b0, addr, '0);
        axil_rsp.arready = 1'b1;
        next_cycle();  // ar handshake on this edge
        axil_rsp.arready = 1'b0;
        random_wait(1'b0, 1'b0, 1'b0, addr, '0);
        axil_rsp.rvalid = 1'b1;
        axil_rsp.rdata  = mem[addr[8:1]];
        seen = 1'b0;
        while (!seen) begin
            seen = axil_req.rready;  // r handshake at the coming edge
            next_cycle();
        end
        axil_rsp.rvalid = 1'b0;
    endtask

    task automatic serve_write();
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
        logic [31:0]       expected;
        logic              seen;
        addr = axil_req.awaddr;
        data = axil_req.wdata;
        check_value("wvalid", 32'(axil_req.wvalid), 1);  // raised with awvalid
        check_value("wstrb", 32'(axil_req.wstrb), 32'h3);  // both byte lanes
        if (exp_q.size() == 0) begin
            $display("store to address %h that the program should not make", addr);
            fail_run();
        end
        expected = exp_q.pop_front();
        check_value("awaddr", 32'(addr), 32'(expected[31:16]));
        check_value("wdata", 32'(data), 32'(expected[15:0]));
        random_wait(1'b0, 1'b1, 1'b1, addr, data);
        axil_rsp.awready = 1'b1;
        next_cycle();
        axil_rsp.awready = 1'b0;
        random_wait(1'b0, 1'b0, 1'b1, addr, data);  // w still open on its own
        axil_rsp.wready = 1'b1;
        next_cycle();
        axil_rsp.wready = 1'b0;
        mem[addr[8:1]] = data;
        store_count++;
        random_wait(1'b0, 1'b0, 1'b0, addr, data);
        axil_rsp.bvalid = 1'b1;
        seen = 1'b0;
        while (!seen) begin
            seen = axil_req.bready;
            next_cycle();
        end
        axil_rsp.bvalid = 1'b0;
    endtask

    task automatic serve_bus();
        forever begin
            next_cycle();
            if (axil_req.arvalid) begin
                serve_read();
            end else if (axil_req.awvalid) begin
                serve_write();
            end
        end
    endtask

    task automatic watchdog();
        repeat (timeout_cycles) @(posedge clk);
        $display("no halt before timeout");
        fail_run();
    endtask

    task automatic load_testdata();
        int          fd;
        int          rc;
        int          c;
        byte         kind;
        logic [15:0] a;
        logic [15:0] d;
        fd = $fopen("cpu_core_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open cpu_core_testdata.txt");
            fail_run();
        end
        while ($fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                c = $fgetc(fd);
                while (c != 10 && c != -1) begin  // rest of the comment line
                    c = $fgetc(fd);
                end
            end else if (kind == "C") begin
                rc = $fscanf(fd, "%d", exp_count);
                if (rc != 1) begin
                    $display("testdata count line has no number");
                    fail_run();
                end
            end else if (kind == "P" || kind == "W") begin
                rc = $fscanf(fd, "%h %h", a, d);
                if (rc != 2) begin
                    $display("testdata line %c has no address and word", kind);
                    fail_run();
                end
                if (kind == "P") begin
                    mem[a[8:1]] = d;  // program and data preload
                end else begin
                    exp_q.push_back({a, d});
                end
            end else begin
                $display("testdata has a line of unknown type %c", kind);
                fail_run();
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int i;
        clk         = 1'b0;
        rst_n       = 1'b0;
        axil_rsp    = '0;
        exp_count   = 0;
        store_count = 0;
        first_read  = 1'b1;
        void'($urandom(75437));
        for (i = 0; i < mem_words; i++) begin
            mem[i] = {~i[7:0], i[7:0]};  // filler differs per word
        end
        load_testdata();
        check_value("expected store entries", 32'(exp_q.size()), 32'(exp_count));
        timeout_cycles = 200 * exp_count + 2000;
        fork
            watchdog();
        join_none
        repeat (rst_cycles) begin
            next_cycle();
            check_value("valid and ready bits in reset", handshake_bits(), 0);
            check_value("halted", 32'(halted), 0);
        end
        rst_n = 1'b1;
        check_value("valid and ready bits after reset", handshake_bits(), 0);
        check_value("halted", 32'(halted), 0);
        fork
            serve_bus();
        join_none
        while (!halted) begin
            next_cycle();
        end
        repeat (16) begin  // parked core stays quiet
            next_cycle();
            check_value("halted", 32'(halted), 1);
            check_value("valid and ready bits after halt", handshake_bits(), 0);
        end
        if (store_count == exp_count) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            check_value("store_count", 32'(store_count), 32'(exp_count));
        end
    end

endmodule

`default_nettype wire

// File: cpu_core.sv
`default_nettype none

module cpu_core (
    input  wire logic                clk,
    input  wire logic                rst_n,
    output cpu_pkg::axil_req_t       axil_req,
    input  wire cpu_pkg::axil_rsp_t  axil_rsp,
    output logic                     halted
);
    import cpu_pkg::*;

    phase_t            phase;
    logic              fetch_busy;
    logic              mem_busy;
    logic              halt;
    logic [addr_w-1:0] pc;
    mem_req_t          fetch_req;
    logic [data_w-1:0] fetch_rdata;
    logic              fetch_done;
    instr_t            instr;
    decoded_t          dec;
    exec_result_t      exr;
    logic [data_w-1:0] load_data;
    logic              rf_we;
    logic [2:0]        rf_waddr;
    logic [data_w-1:0] rf_wdata;

    phase_sequencer i_phase_sequencer (
        .clk, .rst_n, .fetch_busy, .mem_busy, .halt, .phase, .halted
    );

    fetch_stage i_fetch_stage (
        .clk, .rst_n, .phase, .pc, .fetch_req, .fetch_rdata, .fetch_done, .fetch_busy, .instr
    );

    decode_stage i_decode_stage (
        .clk, .rst_n, .phase, .instr, .rf_we, .rf_waddr, .rf_wdata, .dec
    );

    execute_stage i_execute_stage (
        .clk, .rst_n, .phase, .pc, .dec, .exr
    );

    axil_master i_axil_master (  // shared instruction and data port
        .clk, .rst_n, .phase, .fetch_req, .exr, .axil_req, .axil_rsp,
        .fetch_rdata, .fetch_done, .load_data, .mem_busy
    );

    writeback_stage i_writeback_stage (
        .clk, .rst_n, .phase, .exr, .load_data, .pc, .rf_we, .rf_waddr, .rf_wdata, .halt
    );

endmodule

`default_nettype wire

// File: writeback_stage.sv
`default_nettype none

module writeback_stage (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire cpu_pkg::phase_t             phase,
    input  wire cpu_pkg::exec_result_t       exr,
    input  wire logic [cpu_pkg::data_w-1:0]  load_data,
    output logic [cpu_pkg::addr_w-1:0]       pc,
    output logic                             rf_we,
    output logic [2:0]                       rf_waddr,
    output logic [cpu_pkg::data_w-1:0]       rf_wdata,
    output logic                             halt
);
    import cpu_pkg::*;

    logic in_wb;
    logic writes_rd;  // opcode has a register result

    assign in_wb = (phase == PH_WRITEBACK);

    always_comb begin
        unique case (exr.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_LD: writes_rd = 1'b1;
            default:                                       writes_rd = 1'b0;
        endcase
    end

    assign rf_we    = in_wb && writes_rd;
    assign rf_waddr = exr.rd;
    assign rf_wdata = (exr.opcode == OP_LD) ? load_data : exr.alu;
    assign halt     = in_wb && (exr.opcode == OP_HALT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;  // first fetch at 0
        end else if (in_wb && !halt) begin
            pc <= exr.branch_taken ? exr.branch_target : pc + addr_w'(2);
        end
    end

endmodule

`default_nettype wire

// File: axil_master.sv
`default_nettype none

module axil_master (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire cpu_pkg::phase_t             phase,
    input  wire cpu_pkg::mem_req_t           fetch_req,
    input  wire cpu_pkg::exec_result_t       exr,
    output cpu_pkg::axil_req_t               axil_req,
    input  wire cpu_pkg::axil_rsp_t          axil_rsp,
    output logic [cpu_pkg::data_w-1:0]       fetch_rdata,
    output logic                             fetch_done,
    output logic [cpu_pkg::data_w-1:0]       load_data,
    output logic                             mem_busy
);
    import cpu_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RADDR,  // arvalid until arready
        ST_RDATA,  // rready until rvalid
        ST_WRITE,  // aw and w in flight
        ST_WRESP   // bready until bvalid
    } state_t;

    state_t            state;
    mem_req_t          mem_req;   // ld/st request from exr
    mem_req_t          req;       // request taken in idle
    logic              is_mem_op;
    logic              is_fetch;  // current read is an instruction fetch
    logic              aw_pend;
    logic              w_pend;
    logic              aw_hs;
    logic              w_hs;
    logic              rd_hs;
    logic [addr_w-1:0] addr_q;
    logic [data_w-1:0] wdata_q;

    assign is_mem_op = (exr.opcode == OP_LD) || (exr.opcode == OP_ST);

    always_comb begin
        mem_req       = '0;
        mem_req.valid = (phase == PH_MEMORY) && is_mem_op;
        mem_req.write = (exr.opcode == OP_ST);
        mem_req.addr  = exr.addr;
        mem_req.wdata = exr.wdata;
    end

    assign req = fetch_req.valid ? fetch_req : mem_req;  // phases never overlap

    always_comb begin
        axil_req         = '0;
        axil_req.arvalid = (state == ST_RADDR);
        axil_req.araddr  = addr_q;
        axil_req.rready  = (state == ST_RDATA);
        axil_req.awvalid = (state == ST_WRITE) && aw_pend;
        axil_req.awaddr  = addr_q;
        axil_req.wvalid  = (state == ST_WRITE) && w_pend;
        axil_req.wdata   = wdata_q;
        axil_req.wstrb   = '1;  // full words only
        axil_req.bready  = (state == ST_WRESP);
    end

    assign aw_hs = axil_req.awvalid && axil_rsp.awready;
    assign w_hs  = axil_req.wvalid && axil_rsp.wready;
    assign rd_hs = axil_req.rready && axil_rsp.rvalid;

    assign fetch_rdata = axil_rsp.rdata;
    assign fetch_done  = rd_hs && is_fetch;
    // clears in the cycle the ld/st completes
    assign mem_busy = mem_req.valid &&
                      !((rd_hs && !is_fetch) || (axil_req.bready && axil_rsp.bvalid));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            is_fetch <= 1'b0;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
        end else begin
            unique case (state)
                ST_IDLE: if (req.valid) begin
                    is_fetch <= fetch_req.valid;
                    aw_pend  <= req.write;
                    w_pend   <= req.write;
                    state    <= req.write ? ST_WRITE : ST_RADDR;
                end
                ST_RADDR: if (axil_rsp.arready) state <= ST_RDATA;
                ST_RDATA: if (axil_rsp.rvalid) state <= ST_IDLE;
                ST_WRITE: begin
                    if (aw_hs) aw_pend <= 1'b0;  // each channel drops on its own
                    if (w_hs) w_pend <= 1'b0;
                    if ((!aw_pend || aw_hs) && (!w_pend || w_hs)) state <= ST_WRESP;
                end
                ST_WRESP: if (axil_rsp.bvalid) state <= ST_IDLE;  // bresp ignored
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req.valid) begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata;
        end
        if (rd_hs && !is_fetch) begin
            load_data <= axil_rsp.rdata;  // used in writeback
        end
    end

    // address channels hold valid and payload until accepted
    assert property (@(posedge clk) disable iff (!rst_n)
        axil_req.arvalid && !axil_rsp.arready |=> axil_req.arvalid && $stable(axil_req.araddr));
    assert property (@(posedge clk) disable iff (!rst_n)
        axil_req.awvalid && !axil_rsp.awready |=> axil_req.awvalid && $stable(axil_req.awaddr));

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none

module execute_stage (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire cpu_pkg::phase_t             phase,
    input  wire logic [cpu_pkg::addr_w-1:0]  pc,
    input  wire cpu_pkg::decoded_t           dec,
    output cpu_pkg::exec_result_t            exr
);
    import cpu_pkg::*;

    logic [data_w-1:0] alu;
    logic [addr_w-1:0] imm_x2;  // word offset in bytes

    assign imm_x2 = {dec.imm[addr_w-2:0], 1'b0};

    always_comb begin
        unique case (dec.opcode)
            OP_ADD:  alu = dec.rs_val + dec.rt_val;  // wraps at 16 bits
            OP_SUB:  alu = dec.rs_val - dec.rt_val;
            OP_AND:  alu = dec.rs_val & dec.rt_val;
            OP_OR:   alu = dec.rs_val | dec.rt_val;
            OP_ADDI: alu = dec.rs_val + dec.imm;
            default: alu = '0;  // ld/st/beq/halt write no alu value
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exr <= '0;
        end else if (phase == PH_EXECUTE) begin
            exr.opcode        <= dec.opcode;
            exr.rd            <= dec.rd;
            exr.alu           <= alu;
            exr.addr          <= dec.rs_val + imm_x2;  // ld/st address
            exr.wdata         <= dec.rt_val;           // st data from rd
            exr.branch_taken  <= (dec.opcode == OP_BEQ) && (dec.rs_val == dec.rt_val);
            exr.branch_target <= pc + addr_w'(2) + imm_x2;
        end
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire cpu_pkg::phase_t             phase,
    input  wire cpu_pkg::instr_t             instr,
    input  wire logic                        rf_we,
    input  wire logic [2:0]                  rf_waddr,
    input  wire logic [cpu_pkg::data_w-1:0]  rf_wdata,
    output cpu_pkg::decoded_t                dec
);
    import cpu_pkg::*;

    logic [data_w-1:0] rf [reg_count];  // register file
    logic [2:0]        rt_idx;           // second source index
    logic [data_w-1:0] rs_val;
    logic [data_w-1:0] rt_val;

    // st and beq read rd, r-type reads imm[2:0]
    assign rt_idx = (instr.opcode == OP_ST || instr.opcode == OP_BEQ) ? instr.rd
                                                                      : instr.imm[2:0];

    assign rs_val = (instr.rs == 3'd0) ? '0 : rf[instr.rs];  // r0 reads zero
    assign rt_val = (rt_idx == 3'd0) ? '0 : rf[rt_idx];

    always_ff @(posedge clk) begin
        if (rf_we) begin
            rf[rf_waddr] <= rf_wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec <= '0;
        end else if (phase == PH_DECODE) begin
            dec.opcode <= instr.opcode;
            dec.rd     <= instr.rd;
            dec.rs_val <= rs_val;
            dec.rt_val <= rt_val;
            dec.imm    <= {{(data_w - 6){instr.imm[5]}}, instr.imm};  // sign extend
        end
    end

endmodule

`default_nettype wire

// File: fetch_stage.sv
`default_nettype none

module fetch_stage (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire cpu_pkg::phase_t             phase,
    input  wire logic [cpu_pkg::addr_w-1:0]  pc,
    output cpu_pkg::mem_req_t                fetch_req,
    input  wire logic [cpu_pkg::data_w-1:0]  fetch_rdata,
    input  wire logic                        fetch_done,
    output logic                             fetch_busy,
    output cpu_pkg::instr_t                  instr
);
    import cpu_pkg::*;

    logic in_fetch;
    logic pending;  // read issued and word not back yet

    assign in_fetch = (phase == PH_FETCH);

    // single read of pc on phase entry
    always_comb begin
        fetch_req       = '0;
        fetch_req.valid = in_fetch && !pending;
        fetch_req.write = 1'b0;  // instruction reads only
        fetch_req.addr  = pc;
    end

    assign fetch_busy = in_fetch && !fetch_done;  // leave fetch on the data beat

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (fetch_done) begin
            pending <= 1'b0;
        end else if (fetch_req.valid) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= fetch_rdata;  // held through the rest of the instruction
        end
    end

    // the bus returns a word only for a read that was asked for
    assert property (@(posedge clk) disable iff (!rst_n) fetch_done |-> pending);

    // an outstanding read holds the core in fetch and raises no second request
    assert property (@(posedge clk) disable iff (!rst_n)
        pending && !fetch_done |=> in_fetch && !fetch_req.valid);

endmodule

`default_nettype wire

// File: phase_sequencer.sv
`default_nettype none

module phase_sequencer (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            fetch_busy,  // read still outstanding
    input  wire logic            mem_busy,    // ld/st still outstanding
    input  wire logic            halt,        // halt seen in writeback
    output cpu_pkg::phase_t      phase,
    output logic                 halted
);
    import cpu_pkg::*;

    phase_t phase_nxt;

    // ring order, each phase may hold on its own stall
    always_comb begin
        unique case (phase)
            PH_FETCH:     phase_nxt = fetch_busy ? PH_FETCH : PH_DECODE;
            PH_DECODE:    phase_nxt = PH_EXECUTE;
            PH_EXECUTE:   phase_nxt = PH_MEMORY;
            PH_MEMORY:    phase_nxt = mem_busy ? PH_MEMORY : PH_WRITEBACK;
            PH_WRITEBACK: phase_nxt = halt ? PH_WRITEBACK : PH_FETCH;  // halt parks here
            default:      phase_nxt = PH_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase  <= PH_FETCH;  // start fetching pc 0
            halted <= 1'b0;
        end else begin
            phase  <= phase_nxt;
            halted <= halted || (phase == PH_WRITEBACK && halt);  // sticky
        end
    end

    // one phase active at any time
    assert property (@(posedge clk) disable iff (!rst_n) $onehot(phase));

    // once halted, no phase leaves writeback again
    assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> phase == PH_WRITEBACK);

endmodule

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int data_w    = 16;  // datapath width
    localparam int addr_w    = 16;  // byte addresses, 2 bytes per word
    localparam int reg_count = 8;   // r0 reads as zero

    // R-type ops take rt from imm[2:0]
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,  // rd = rs + rt
        OP_SUB  = 4'h1,  // rd = rs - rt
        OP_AND  = 4'h2,  // rd = rs & rt
        OP_OR   = 4'h3,  // rd = rs | rt
        OP_ADDI = 4'h4,  // rd = rs + imm
        OP_LD   = 4'h5,  // rd = mem[rs + imm*2]
        OP_ST   = 4'h6,  // mem[rs + imm*2] = rd
        OP_BEQ  = 4'h7,  // if rs == rd, pc = pc + 2 + imm*2
        OP_HALT = 4'h8   // stop in writeback
    } opcode_t;

    typedef enum logic [4:0] {
        PH_FETCH     = 5'b00001,
        PH_DECODE    = 5'b00010,
        PH_EXECUTE   = 5'b00100,
        PH_MEMORY    = 5'b01000,
        PH_WRITEBACK = 5'b10000
    } phase_t;

    typedef struct packed {
        opcode_t           opcode;  // [15:12]
        logic [2:0]        rd;      // [11:9] dest, or 2nd source for st/beq
        logic [2:0]        rs;      // [8:6]
        logic signed [5:0] imm;     // [5:0]
    } instr_t;

    typedef struct packed {
        opcode_t             opcode;
        logic [2:0]          rd;
        logic [data_w-1:0]   rs_val;  // first operand
        logic [data_w-1:0]   rt_val;  // second operand
        logic [data_w-1:0]   imm;     // sign extended
    } decoded_t;

    typedef struct packed {
        opcode_t             opcode;
        logic [2:0]          rd;
        logic [data_w-1:0]   alu;            // alu result
        logic [addr_w-1:0]   addr;           // ld/st address
        logic [data_w-1:0]   wdata;          // st data
        logic                branch_taken;
        logic [addr_w-1:0]   branch_target;
    } exec_result_t;

    typedef struct packed {
        logic                valid;
        logic                write;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic                  awvalid;
        logic [addr_w-1:0]     awaddr;
        logic                  wvalid;
        logic [data_w-1:0]     wdata;
        logic [data_w/8-1:0]   wstrb;
        logic                  bready;
        logic                  arvalid;
        logic [addr_w-1:0]     araddr;
        logic                  rready;
    } axil_req_t;

    typedef struct packed {
        logic                awready;
        logic                wready;
        logic                bvalid;
        logic [1:0]          bresp;
        logic                arready;
        logic                rvalid;
        logic [data_w-1:0]   rdata;
        logic [1:0]          rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire
